//--- hdl/fix_session_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared encodings and packed records of the FIX session engine,
// imported by every block that passes events or actions around
//////////////////////////////////////////////////////////////////////
package fix_session_pkg;

	// inbound message type as decoded by the parser
	typedef enum logic [2:0] {
		logon      = 3'd0,
		business   = 3'd1,
		logout     = 3'd2,
		heartbeat  = 3'd3,
		resend_req = 3'd4,
		seq_reset  = 3'd5,
		gap_fill   = 3'd6
	} msg_type_e;

	// parser verdict, seq_low means too low without PossDup
	typedef enum logic [2:0] {
		valid    = 3'd0,
		seq_high = 3'd1,
		garbled  = 3'd2,
		seq_low  = 3'd3,
		invalid  = 3'd4
	} validity_e;

	// disconnected is zero so a cleared table means no sessions
	typedef enum logic [3:0] {
		disconnected          = 4'd0,
		normal_session        = 4'd1,
		serving_resend_logout = 4'd2,
		sent_resend_req       = 4'd3,
		sent_heartbeat        = 4'd4,
		resend_req_logout     = 4'd5,
		serving_resend        = 4'd6,
		logout_sent           = 4'd7,
		logon_sent            = 4'd8
	} session_state_e;

	typedef enum logic [1:0] {
		ctrl_connect     = 2'd0,
		ctrl_end_session = 2'd1,
		ctrl_timeout     = 2'd2,
		ctrl_resend_done = 2'd3
	} ctrl_kind_e;

	typedef enum logic [3:0] {
		act_ignore         = 4'd0,
		act_disconnect     = 4'd1,
		act_send_logon     = 4'd2,
		act_send_logout    = 4'd3,
		act_send_heartbeat = 4'd4,
		act_resend_req     = 4'd5,
		act_do_resend      = 4'd6,
		act_deliver        = 4'd7,
		act_update_seq     = 4'd8
	} action_e;

	// cause reported along with a disconnect
	typedef enum logic [1:0] {
		err_none         = 2'd0,
		err_fatal_manual = 2'd1,
		err_protocol     = 2'd2,
		err_timeout      = 2'd3
	} error_e;

	typedef struct packed {
		msg_type_e msg_type;
		validity_e validity;
	} rx_msg_t;

	// one slot of the merged event stream
	typedef struct packed {
		logic       is_ctrl;
		rx_msg_t    msg;
		ctrl_kind_e ctrl_kind;
	} session_event_t;

	typedef struct packed {
		action_e action;
		error_e  error;
	} session_action_t;

endpackage

//--- hdl/session_ram.sv
//////////////////////////////////////////////////////////////////////
// single-port table RAM with registered read, holds the per-host
// session state and the per-host target CompID
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module session_ram #(
	parameter int DEPTH = 16,
	parameter int WIDTH = 4,
	localparam int ADDR_W = $clog2(DEPTH)
) (
	input  logic              clk,
	input  logic              we_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [WIDTH-1:0]  wdata_i,
	output logic [WIDTH-1:0]  rdata_o
);

	logic [WIDTH-1:0] mem [DEPTH];

	// read returns the old word when the same address is written
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
		rdata_o <= mem[addr_i];
	end

endmodule

//--- hdl/session_event_arbiter.sv
//////////////////////////////////////////////////////////////////////
// merges inbound messages and local control events into one event
// per cycle, messages first, control waits in a one-entry hold
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module session_event_arbiter #(
	parameter int NUM_HOST = 16,
	localparam int HOST_W = $clog2(NUM_HOST)
) (
	input  logic                            clk,
	input  logic                            arst_n_i,
	input  logic                            msg_valid_i,
	input  fix_session_pkg::rx_msg_t        msg_i,
	input  logic [HOST_W-1:0]               msg_host_i,
	input  logic                            ctrl_valid_i,
	input  fix_session_pkg::ctrl_kind_e     ctrl_kind_i,
	input  logic [HOST_W-1:0]               ctrl_host_i,
	input  logic                            hold_i,
	output logic                            evt_valid_o,
	output fix_session_pkg::session_event_t evt_o,
	output logic [HOST_W-1:0]               evt_host_o,
	output logic                            ctrl_overrun_o
);
	import fix_session_pkg::*;

	logic              pend_valid;
	ctrl_kind_e        pend_kind;
	logic [HOST_W-1:0] pend_host;
	logic              msg_take;
	logic              slot_free;
	logic              issue_pend;
	logic              issue_new;
	logic              store_new;

	assign msg_take  = msg_valid_i && !hold_i;
	assign slot_free = !msg_valid_i && !hold_i;

	// pending entry leaves first, a fresh strobe bypasses an empty hold
	assign issue_pend = pend_valid && slot_free;
	assign issue_new  = !pend_valid && ctrl_valid_i && slot_free;
	assign store_new  = ctrl_valid_i && !issue_new && (!pend_valid || issue_pend);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pend_valid     <= 1'b0;
			evt_valid_o    <= 1'b0;
			ctrl_overrun_o <= 1'b0;
		end else begin
			evt_valid_o <= msg_take || issue_pend || issue_new;
			if (store_new) begin
				pend_valid <= 1'b1;
			end else if (issue_pend) begin
				pend_valid <= 1'b0;
			end
			// sticky, hold full and not draining this cycle
			if (ctrl_valid_i && pend_valid && !issue_pend) begin
				ctrl_overrun_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (store_new) begin
			pend_kind <= ctrl_kind_i;
			pend_host <= ctrl_host_i;
		end
		if (msg_take) begin
			evt_o      <= '{is_ctrl: 1'b0, msg: msg_i, ctrl_kind: ctrl_connect};
			evt_host_o <= msg_host_i;
		end else if (issue_pend) begin
			evt_o      <= '{is_ctrl: 1'b1, msg: '{msg_type: logon, validity: valid},
				ctrl_kind: pend_kind};
			evt_host_o <= pend_host;
		end else if (issue_new) begin
			evt_o      <= '{is_ctrl: 1'b1, msg: '{msg_type: logon, validity: valid},
				ctrl_kind: ctrl_kind_i};
			evt_host_o <= ctrl_host_i;
		end
	end

endmodule

//--- hdl/session_fsm.sv
//////////////////////////////////////////////////////////////////////
// session decision pipeline: stage 1 addresses the tables, stage 2
// applies the session rules, writes the state back and emits the action
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module session_fsm #(
	parameter int NUM_HOST = 16,
	parameter int COMP_ID_W = 64,
	localparam int HOST_W = $clog2(NUM_HOST)
) (
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  logic                             evt_valid_i,
	input  fix_session_pkg::session_event_t  evt_i,
	input  logic [HOST_W-1:0]                evt_host_i,
	output logic                             st_we_o,
	output logic [HOST_W-1:0]                tab_addr_o,
	output logic [3:0]                       st_wdata_o,
	input  logic [3:0]                       st_rdata_i,
	input  logic [COMP_ID_W-1:0]             cid_rdata_i,
	output logic                             init_busy_o,
	output logic                             act_valid_o,
	output fix_session_pkg::session_action_t act_o,
	output logic [HOST_W-1:0]                act_host_o,
	output logic [COMP_ID_W-1:0]             act_comp_id_o
);
	import fix_session_pkg::*;

	logic              init_busy;
	logic [HOST_W-1:0] init_cnt;
	logic              s2_valid;
	session_event_t    s2_evt;
	logic [HOST_W-1:0] s2_host;
	msg_type_e         s2_type;
	validity_e         s2_vld;
	logic              wb_valid;
	logic [HOST_W-1:0] wb_host;
	session_state_e    wb_state;
	logic              wr_wb;
	logic              wr_now;
	session_state_e    cur_state;
	session_state_e    nxt_state;
	session_action_t   nxt_act;
	logic              act_en;

	assign init_busy_o = init_busy;
	assign s2_type     = s2_evt.msg.msg_type;
	assign s2_vld      = s2_evt.msg.validity;

	// newest state for the stage 2 host, pending write-back wins over RAM
	assign cur_state = (wb_valid && wb_host == s2_host) ? wb_state
		: session_state_e'(st_rdata_i);

	// session rules, first match wins
	always_comb begin
		nxt_state = cur_state;
		nxt_act   = '{action: act_ignore, error: err_none};
		act_en    = 1'b1;
		if (s2_evt.is_ctrl) begin
			case (s2_evt.ctrl_kind)
				ctrl_connect: begin
					nxt_act.action = act_send_logon;
					nxt_state      = logon_sent;
				end
				ctrl_end_session: begin
					nxt_act.action = act_send_logout;
					nxt_state      = logout_sent;
				end
				ctrl_timeout: begin
					if (cur_state inside {logon_sent, logout_sent, sent_heartbeat}) begin
						nxt_act   = '{action: act_disconnect, error: err_timeout};
						nxt_state = disconnected;
					end else begin
						nxt_act.action = act_send_heartbeat;
						nxt_state      = sent_heartbeat;
					end
				end
				default: begin
					if (cur_state inside {sent_resend_req, serving_resend}) begin
						nxt_act.action = act_deliver;
						nxt_state      = normal_session;
					end else if (cur_state inside {resend_req_logout, serving_resend_logout}) begin
						nxt_act.action = act_send_logout;
						nxt_state      = logout_sent;
					end else begin
						act_en = 1'b0;
					end
				end
			endcase
		end else if (s2_vld == seq_low || s2_vld == invalid) begin
			nxt_act   = '{action: act_disconnect, error: err_fatal_manual};
			nxt_state = disconnected;
		end else if (cur_state == disconnected) begin
			nxt_act = '{action: act_disconnect, error: err_protocol};
		end else if (s2_vld == garbled && cur_state != logon_sent) begin
			nxt_act.action = act_ignore;
		end else begin
			case (cur_state)
				logon_sent: begin
					if (s2_type == logon && s2_vld == valid) begin
						nxt_act.action = act_deliver;
						nxt_state      = normal_session;
					end else if (s2_type == logon && s2_vld == seq_high) begin
						nxt_act.action = act_resend_req;
						nxt_state      = sent_resend_req;
					end else begin
						nxt_act   = '{action: act_disconnect, error: err_protocol};
						nxt_state = disconnected;
					end
				end
				normal_session, sent_heartbeat: begin
					if (s2_type == logout && s2_vld == valid) begin
						nxt_act.action = act_send_logout;
						nxt_state      = disconnected;
					end else if (s2_type == logout && s2_vld == seq_high) begin
						nxt_act.action = act_resend_req;
						nxt_state      = resend_req_logout;
					end else if (s2_type == resend_req) begin
						nxt_act.action = act_do_resend;
						nxt_state      = serving_resend;
					end else if (s2_vld == seq_high) begin
						nxt_act.action = act_resend_req;
						nxt_state      = sent_resend_req;
					end else if (s2_type == heartbeat) begin
						nxt_act.action = act_send_heartbeat;
						nxt_state      = sent_heartbeat;
					end else begin
						nxt_act.action = act_deliver;
						nxt_state      = normal_session;
					end
				end
				logout_sent: begin
					if (s2_type == logout) begin
						nxt_act   = '{action: act_disconnect, error: err_none};
						nxt_state = disconnected;
					end else if (s2_type == resend_req) begin
						nxt_act.action = act_do_resend;
						nxt_state      = serving_resend_logout;
					end else begin
						nxt_act   = '{action: act_disconnect, error: err_protocol};
						nxt_state = disconnected;
					end
				end
				sent_resend_req, resend_req_logout: begin
					if (s2_type == gap_fill || s2_type == seq_reset) begin
						nxt_act.action = act_update_seq;
					end else if (s2_vld == seq_high) begin
						nxt_act.action = act_resend_req;
					end else begin
						nxt_act.action = act_deliver;
					end
				end
				serving_resend, serving_resend_logout: begin
					nxt_act.action = act_deliver;
				end
				default: begin
					nxt_act   = '{action: act_disconnect, error: err_protocol};
					nxt_state = disconnected;
				end
			endcase
		end
	end

	// one table port: init walk, then stage 1 reads, writes use idle cycles.
	// runs of events to three distinct hosts on consecutive cycles
	// overwrite the oldest pending write-back
	always_comb begin
		st_we_o    = 1'b0;
		tab_addr_o = evt_host_i;
		st_wdata_o = nxt_state;
		wr_wb      = 1'b0;
		wr_now     = 1'b0;
		if (init_busy) begin
			st_we_o    = 1'b1;
			tab_addr_o = init_cnt;
			st_wdata_o = disconnected;
		end else if (evt_valid_i) begin
			tab_addr_o = evt_host_i;
		end else if (wb_valid) begin
			st_we_o    = 1'b1;
			tab_addr_o = wb_host;
			st_wdata_o = wb_state;
			wr_wb      = 1'b1;
		end else if (s2_valid) begin
			st_we_o    = 1'b1;
			tab_addr_o = s2_host;
			wr_now     = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			init_busy     <= 1'b1;
			init_cnt      <= '0;
			s2_valid      <= 1'b0;
			wb_valid      <= 1'b0;
			act_valid_o   <= 1'b0;
			act_o         <= '0;
			act_host_o    <= '0;
			act_comp_id_o <= '0;
		end else begin
			if (init_busy) begin
				init_cnt <= init_cnt + 1'b1;
				if (init_cnt == HOST_W'(NUM_HOST - 1)) begin
					init_busy <= 1'b0;
				end
			end
			s2_valid <= evt_valid_i && !init_busy;
			if (s2_valid && !wr_now) begin
				wb_valid <= 1'b1;
			end else if (wr_wb) begin
				wb_valid <= 1'b0;
			end
			act_valid_o <= s2_valid && act_en;
			if (s2_valid && act_en) begin
				act_o         <= nxt_act;
				act_host_o    <= s2_host;
				act_comp_id_o <= cid_rdata_i;
			end
		end
	end

	// stage 1 and write-back payload
	always_ff @(posedge clk) begin
		if (evt_valid_i) begin
			s2_evt  <= evt_i;
			s2_host <= evt_host_i;
		end
		if (s2_valid && !wr_now) begin
			wb_host  <= s2_host;
			wb_state <= nxt_state;
		end
	end

endmodule

//--- hdl/session_manager_top.sv
//////////////////////////////////////////////////////////////////////
// FIX session engine top: event arbiter, decision pipeline and the
// two per-host tables, CompIDs are provisioned while traffic is idle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module session_manager_top #(
	parameter int NUM_HOST = 16,
	parameter int COMP_ID_W = 64,
	localparam int HOST_W = $clog2(NUM_HOST)
) (
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  logic                             msg_valid_i,
	input  fix_session_pkg::rx_msg_t         msg_i,
	input  logic [HOST_W-1:0]                msg_host_i,
	input  logic                             ctrl_valid_i,
	input  fix_session_pkg::ctrl_kind_e      ctrl_kind_i,
	input  logic [HOST_W-1:0]                ctrl_host_i,
	input  logic                             cfg_we_i,
	input  logic [HOST_W-1:0]                cfg_host_i,
	input  logic [COMP_ID_W-1:0]             cfg_comp_id_i,
	output logic                             act_valid_o,
	output fix_session_pkg::session_action_t act_o,
	output logic [HOST_W-1:0]                act_host_o,
	output logic [COMP_ID_W-1:0]             act_comp_id_o,
	output logic                             ctrl_overrun_o
);
	import fix_session_pkg::*;

	logic                 evt_valid;
	session_event_t       evt;
	logic [HOST_W-1:0]    evt_host;
	logic                 init_busy;
	logic                 st_we;
	logic [HOST_W-1:0]    tab_addr;
	logic [3:0]           st_wdata;
	logic [3:0]           st_rdata;
	logic [HOST_W-1:0]    cid_addr;
	logic [COMP_ID_W-1:0] cid_rdata;

	// provisioning takes the CompID port
	assign cid_addr = cfg_we_i ? cfg_host_i : tab_addr;

	session_event_arbiter #(.NUM_HOST(NUM_HOST)) arb_i (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.msg_valid_i    (msg_valid_i),
		.msg_i          (msg_i),
		.msg_host_i     (msg_host_i),
		.ctrl_valid_i   (ctrl_valid_i),
		.ctrl_kind_i    (ctrl_kind_i),
		.ctrl_host_i    (ctrl_host_i),
		.hold_i         (init_busy),
		.evt_valid_o    (evt_valid),
		.evt_o          (evt),
		.evt_host_o     (evt_host),
		.ctrl_overrun_o (ctrl_overrun_o)
	);

	session_fsm #(.NUM_HOST(NUM_HOST), .COMP_ID_W(COMP_ID_W)) fsm_i (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.evt_valid_i   (evt_valid),
		.evt_i         (evt),
		.evt_host_i    (evt_host),
		.st_we_o       (st_we),
		.tab_addr_o    (tab_addr),
		.st_wdata_o    (st_wdata),
		.st_rdata_i    (st_rdata),
		.cid_rdata_i   (cid_rdata),
		.init_busy_o   (init_busy),
		.act_valid_o   (act_valid_o),
		.act_o         (act_o),
		.act_host_o    (act_host_o),
		.act_comp_id_o (act_comp_id_o)
	);

	session_ram #(.DEPTH(NUM_HOST), .WIDTH(4)) state_tab (
		.clk     (clk),
		.we_i    (st_we),
		.addr_i  (tab_addr),
		.wdata_i (st_wdata),
		.rdata_o (st_rdata)
	);

	session_ram #(.DEPTH(NUM_HOST), .WIDTH(COMP_ID_W)) comp_id_tab (
		.clk     (clk),
		.we_i    (cfg_we_i),
		.addr_i  (cid_addr),
		.wdata_i (cfg_comp_id_i),
		.rdata_o (cid_rdata)
	);

endmodule

//--- tb/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// free-running testbench clock, period given in ns by parameter
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2.0) clk_o = ~clk_o;
		end
	end

endmodule

//--- tb/session_manager_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the FIX session engine
// replays the pattern file on the falling edge and checks every
// action pulse in arrival order
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module session_manager_tb;
	import fix_session_pkg::*;

	localparam int NUM_HOST    = 16;
	localparam int COMP_ID_W   = 64;
	localparam int HOST_W      = $clog2(NUM_HOST);
	localparam int MAX_REC     = 80;
	localparam int REC_W       = 9;
	localparam int MEM_WORDS   = MAX_REC * REC_W;
	localparam int IDX_W       = $clog2(MEM_WORDS);
	localparam int RST_CYCLES  = 10;
	localparam int INIT_CYCLES = NUM_HOST + 4;
	localparam int CYC_PER_REC = 20;

	// word positions inside one record
	localparam int COL_OP   = 0;
	localparam int COL_GRP  = 1;
	localparam int COL_HOST = 2;
	localparam int COL_TYPE = 3;
	localparam int COL_VLD  = 4;
	localparam int COL_EXP  = 5;
	localparam int COL_ACT  = 6;
	localparam int COL_ERR  = 7;
	localparam int COL_CID  = 8;

	typedef struct packed {
		session_action_t      resp;
		logic [HOST_W-1:0]    host;
		logic [COMP_ID_W-1:0] comp_id;
	} expect_t;

	logic                 clk;
	logic                 arst_n;
	logic                 msg_valid;
	rx_msg_t              msg;
	logic [HOST_W-1:0]    msg_host;
	logic                 ctrl_valid;
	ctrl_kind_e           ctrl_kind;
	logic [HOST_W-1:0]    ctrl_host;
	logic                 cfg_we;
	logic [HOST_W-1:0]    cfg_host;
	logic [COMP_ID_W-1:0] cfg_comp_id;
	logic                 act_valid;
	session_action_t      act;
	logic [HOST_W-1:0]    act_host;
	logic [COMP_ID_W-1:0] act_comp_id;
	logic                 ctrl_overrun;

	logic [63:0]          pat_mem [MEM_WORDS];
	logic [COMP_ID_W-1:0] comp_tab [NUM_HOST];
	expect_t              exp_q [$];
	integer               seed;
	int                   num_records = 0;

	tb_clock_gen #(.PERIOD_NS(4.0)) clk_gen_i (.clk_o(clk));

	session_manager_top #(.NUM_HOST(NUM_HOST), .COMP_ID_W(COMP_ID_W)) dut_i (
		.clk            (clk),
		.arst_n_i       (arst_n),
		.msg_valid_i    (msg_valid),
		.msg_i          (msg),
		.msg_host_i     (msg_host),
		.ctrl_valid_i   (ctrl_valid),
		.ctrl_kind_i    (ctrl_kind),
		.ctrl_host_i    (ctrl_host),
		.cfg_we_i       (cfg_we),
		.cfg_host_i     (cfg_host),
		.cfg_comp_id_i  (cfg_comp_id),
		.act_valid_o    (act_valid),
		.act_o          (act),
		.act_host_o     (act_host),
		.act_comp_id_o  (act_comp_id),
		.ctrl_overrun_o (ctrl_overrun)
	);

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		if (got !== want) begin
			$display("ERR %s: got %h expected %h", name, got, want);
			$display("Simulation failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	function automatic logic [63:0] pattern_word(input int rec, input int col);
		return pat_mem[IDX_W'(rec * REC_W + col)];
	endfunction

	function automatic logic [3:0] pattern_nibble(input int rec, input int col);
		logic [63:0] w;
		w = pattern_word(rec, col);
		return w[3:0];
	endfunction

	function automatic logic [HOST_W-1:0] record_host(input int rec);
		logic [63:0] w;
		w = pattern_word(rec, COL_HOST);
		return w[HOST_W-1:0];
	endfunction

	// cycle offset of a record inside its group
	function automatic int record_slot(input int rec);
		logic [3:0] g;
		g = pattern_nibble(rec, COL_GRP);
		return int'(g[2:0]);
	endfunction

	task automatic drive_idle();
		msg_valid   = 1'b0;
		msg         = '{msg_type: logon, validity: valid};
		msg_host    = '0;
		ctrl_valid  = 1'b0;
		ctrl_kind   = ctrl_connect;
		ctrl_host   = '0;
		cfg_we      = 1'b0;
		cfg_host    = '0;
		cfg_comp_id = '0;
	endtask

	task automatic apply_record(input int rec);
		logic [3:0] op;
		logic [3:0] kind;
		logic [3:0] vld;
		op   = pattern_nibble(rec, COL_OP);
		kind = pattern_nibble(rec, COL_TYPE);
		vld  = pattern_nibble(rec, COL_VLD);
		case (op)
			4'h0: begin
				cfg_we      = 1'b1;
				cfg_host    = record_host(rec);
				cfg_comp_id = COMP_ID_W'(pattern_word(rec, COL_CID));
			end
			4'h1: begin
				msg_valid = 1'b1;
				msg       = '{msg_type: msg_type_e'(kind[2:0]), validity: validity_e'(vld[2:0])};
				msg_host  = record_host(rec);
			end
			4'h2: begin
				ctrl_valid = 1'b1;
				ctrl_kind  = ctrl_kind_e'(kind[1:0]);
				ctrl_host  = record_host(rec);
			end
			default: begin
				$display("pattern record %0d has an unknown op %h", rec, op);
				$display("Simulation failed");
				$fatal(1, "bad pattern record");
			end
		endcase
	endtask

	// CompID table follows provisioning and actions queue in file order
	task automatic model_record(input int rec);
		expect_t    e;
		logic [3:0] act_nib;
		logic [3:0] err_nib;
		act_nib = pattern_nibble(rec, COL_ACT);
		err_nib = pattern_nibble(rec, COL_ERR);
		if (pattern_nibble(rec, COL_OP) == 4'h0) begin
			comp_tab[record_host(rec)] = COMP_ID_W'(pattern_word(rec, COL_CID));
		end else if (pattern_nibble(rec, COL_EXP) != 4'h0) begin
			e.resp.action = action_e'(act_nib);
			e.resp.error  = error_e'(err_nib[1:0]);
			e.host        = record_host(rec);
			e.comp_id     = comp_tab[record_host(rec)];
			exp_q.push_back(e);
		end
	endtask

	// a group shares cycle slots and is followed by three or more idle cycles
	task automatic run_group(input int first, output int next);
		int last;
		int max_slot;
		int gap;
		int r;
		int s;
		last = first;
		while (last + 1 < num_records && (pattern_nibble(last, COL_GRP) & 4'h8) != 4'h0) begin
			last++;
		end
		max_slot = 0;
		for (r = first; r <= last; r++) begin
			model_record(r);
			if (record_slot(r) > max_slot) begin
				max_slot = record_slot(r);
			end
		end
		for (s = 0; s <= max_slot; s++) begin
			@(negedge clk);
			drive_idle();
			for (r = first; r <= last; r++) begin
				if (record_slot(r) == s) begin
					apply_record(r);
				end
			end
		end
		@(negedge clk);
		drive_idle();
		gap = 3 + ($random(seed) & 3);
		repeat (gap - 1) @(negedge clk);
		next = last + 1;
	endtask

	always @(negedge clk) begin : action_monitor
		expect_t want;
		if (act_valid) begin
			if (exp_q.size() == 0) begin
				$display("action %0d on host %0d arrived with nothing expected",
					act.action, act_host);
				$display("Simulation failed");
				$fatal(1, "unexpected action");
			end else begin
				want = exp_q.pop_front();
				check_value("act_o.action", 64'(act.action), 64'(want.resp.action));
				check_value("act_o.error", 64'(act.error), 64'(want.resp.error));
				check_value("act_host_o", 64'(act_host), 64'(want.host));
				check_value("act_comp_id_o", 64'(act_comp_id), 64'(want.comp_id));
			end
		end
	end

	initial begin : watchdog
		wait (num_records > 0);
		repeat (RST_CYCLES + INIT_CYCLES + num_records * CYC_PER_REC) @(posedge clk);
		$display("run did not finish in time, %0d actions still outstanding", exp_q.size());
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial begin : stimulus
		int rec;
		int n_rec;
		seed   = 32'h4cdc;
		arst_n = 1'b0;
		drive_idle();
		$readmemh("tb/session_patterns.mem", pat_mem);
		n_rec = 0;
		while (n_rec < MAX_REC && pattern_nibble(n_rec, COL_OP) != 4'hf) begin
			n_rec++;
		end
		if (n_rec == 0 || n_rec == MAX_REC) begin
			$display("pattern file is empty or has no end record");
			$display("Simulation failed");
			$fatal(1, "bad pattern file");
		end
		num_records = n_rec;

		repeat (RST_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		// table clear walk in the FSM
		repeat (INIT_CYCLES) @(negedge clk);

		rec = 0;
		while (rec < n_rec) begin
			run_group(rec, rec);
		end

		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		// late or extra pulses still reach the monitor
		repeat (8) @(negedge clk);
		check_value("ctrl_overrun_o", 64'(ctrl_overrun), 64'd1);

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- filelist.f
hdl/fix_session_pkg.sv
hdl/session_ram.sv
hdl/session_event_arbiter.sv
hdl/session_fsm.sv
hdl/session_manager_top.sv
tb/tb_clock_gen.sv
tb/session_manager_tb.sv

//--- Makefile
# Verilator build and run of the FIX session engine testbench

TOP := session_manager_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

# the run exits with a failing status when the testbench calls $fatal
sim:
	verilator --binary --timing --top-module $(TOP) -f filelist.f \
		-Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- tb/session_patterns.mem
// op grp host type vld exp act err comp_id, op 0 provision 1 message 2 control f end
// grp bit 3 means the next record shares the group, bits 2:0 the cycle slot in it
0 0 1 0 0 0 0 0 46495831534e4431
0 0 2 0 0 0 0 0 46495831534e4432
0 0 3 0 0 0 0 0 46495831534e4433
0 0 5 0 0 0 0 0 46495831534e4435
// host 1 lifecycle
2 0 1 0 0 1 2 0 0
1 0 1 0 0 1 7 0 0
1 0 1 1 0 1 7 0 0
2 0 1 1 0 1 3 0 0
1 0 1 2 0 1 1 0 0
// host 2 gap handling
2 0 2 0 0 1 2 0 0
1 0 2 0 0 1 7 0 0
1 0 2 1 1 1 5 0 0
1 0 2 6 0 1 8 0 0
1 0 2 1 0 1 7 0 0
2 0 2 3 0 1 7 0 0
2 0 2 3 0 0 0 0 0
1 0 2 1 0 1 7 0 0
// host 3 fatal validity, garbled and timeouts
2 0 3 0 0 1 2 0 0
1 0 3 0 0 1 7 0 0
1 0 3 1 2 1 0 0 0
2 0 3 2 0 1 4 0 0
2 0 3 2 0 1 1 3 0
1 0 3 1 0 1 1 2 0
2 0 3 0 0 1 2 0 0
1 0 3 0 0 1 7 0 0
1 0 3 1 3 1 1 1 0
2 0 3 0 0 1 2 0 0
1 0 3 0 0 1 7 0 0
1 0 3 3 4 1 1 1 0
// host 5 back to back, then hosts 2 and 5 interleaved
2 0 5 0 0 1 2 0 0
1 0 5 0 0 1 7 0 0
1 8 5 3 0 1 4 0 0
1 1 5 4 0 1 6 0 0
1 0 5 1 0 1 7 0 0
2 0 5 3 0 1 7 0 0
1 0 2 1 1 1 5 0 0
1 0 5 3 0 1 4 0 0
1 0 2 3 0 1 7 0 0
2 0 5 2 0 1 1 3 0
2 0 2 3 0 1 7 0 0
1 8 2 1 0 1 7 0 0
1 1 1 1 0 1 1 2 0
// logout paths through both serving states
2 0 5 0 0 1 2 0 0
1 0 5 0 0 1 7 0 0
2 0 5 1 0 1 3 0 0
1 0 5 4 0 1 6 0 0
2 0 5 3 0 1 3 0 0
1 0 5 2 0 1 1 0 0
1 0 2 2 1 1 5 0 0
1 0 2 5 0 1 8 0 0
2 0 2 3 0 1 3 0 0
1 0 2 1 0 1 1 2 0
// control beside messages, second control overruns the hold
2 0 1 0 0 1 2 0 0
1 8 1 0 0 1 7 0 0
1 9 1 1 0 1 7 0 0
2 8 3 0 0 1 2 0 0
2 1 3 2 0 0 0 0 0
1 0 3 0 0 1 7 0 0
f 0 0 0 0 0 0 0 0
